// File: design/readout_settings.svh
// Sizing constants for the detector readout controller.
// Included by the package and by every RTL module that needs a width or count.
`ifndef READOUT_SETTINGS_SVH
`define READOUT_SETTINGS_SVH

// channel side
`define READOUT_CHANNELS     8
`define READOUT_CHAN_ID_W    3
`define READOUT_PAYLOAD_W    116
`define READOUT_FILL_W       10

// frame side
`define READOUT_WORD_W       120
`define READOUT_PERIOD_W     12
`define READOUT_DATA_SLOTS   16
`define READOUT_FRAME_WORDS  18   // header + data slots + trailer
`define READOUT_WORD_BYTES   15
`define READOUT_FIFO_DEPTH   32   // power of two, pointers wrap freely

`endif

// File: design/readout_pkg.sv
// Shared packed types for the readout pipeline.
// Stages refer to these by scoped name, readout_pkg::<type>.
`include "readout_settings.svh"

package readout_pkg;

	// ============================================================
	// channel FIFO status, one entry per channel
	// ============================================================
	typedef struct packed {
		logic                         empty;  // FWFT empty flag
		logic [`READOUT_FILL_W-1:0]   fill;   // words held
	} chan_status_t;

	// ============================================================
	// result of one scan slot
	// ============================================================
	typedef struct packed {
		logic                            hit;      // low means filler
		logic [`READOUT_CHAN_ID_W-1:0]   chan;
		logic [`READOUT_PAYLOAD_W-1:0]   payload;
	} scan_item_t;

	// ============================================================
	// one word of a frame as it moves through the word FIFO
	// ============================================================
	typedef struct packed {
		logic                         last;   // trailer of the frame
		logic [`READOUT_WORD_W-1:0]   data;
	} frame_word_t;

endpackage

// File: design/readout_timer.sv
// Readout period counter.
// Counts 0..counter_th and pulses frame_tick on the last count, so one
// frame opportunity comes every counter_th+1 cycles.
`timescale 1ns/1ps
`include "readout_settings.svh"

module readout_timer (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`READOUT_PERIOD_W-1:0]  counter_th,
	output logic                          frame_tick
);

	logic [`READOUT_PERIOD_W-1:0] count;
	logic                         wrap;

	assign wrap = (count == counter_th);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (wrap) begin
			count <= '0;  // period restarts
		end else begin
			count <= count + 1'b1;
		end
	end

	// one cycle wide, at the end of each period
	assign frame_tick = wrap;

endmodule

// File: design/channel_scan.sv
// Priority scan over the eight channel FIFOs.
// scan_start snapshots the not-empty flags; each scan_step reads the
// highest-numbered pending channel and returns its tagged payload.
`timescale 1ns/1ps
`include "readout_settings.svh"

module channel_scan (
	input  logic                                                  clk,
	input  logic                                                  reset,
	input  logic                                                  scan_start,
	input  logic                                                  scan_step,
	input  readout_pkg::chan_status_t [`READOUT_CHANNELS-1:0]     chan_status,
	input  logic [`READOUT_CHANNELS-1:0][`READOUT_PAYLOAD_W-1:0]  chan_payload,
	output logic [`READOUT_CHANNELS-1:0]                          chan_read,
	output readout_pkg::scan_item_t                               item
);

	logic [`READOUT_CHANNELS-1:0]  not_empty;
	logic [`READOUT_CHANNELS-1:0]  mask;     // channels still owed a read this pass
	logic [`READOUT_CHANNELS-1:0]  pending;  // mask seen by the current step
	logic [`READOUT_CHANNELS-1:0]  pick;
	logic [`READOUT_CHAN_ID_W-1:0] pick_id;
	logic                          found;

	always_comb begin
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			not_empty[i] = ~chan_status[i].empty;
		end
	end

	// empty mask reloads from the live flags
	assign pending = (mask == '0) ? not_empty : mask;
	assign found   = |pending;

	// ============================================================
	// priority pick, highest channel wins
	// ============================================================
	always_comb begin
		pick_id = '0;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			if (pending[i]) begin
				pick_id = `READOUT_CHAN_ID_W'(i);  // later index overrides
			end
		end
	end

	assign pick      = found ? (`READOUT_CHANNELS'(1) << pick_id) : '0;
	assign chan_read = scan_step ? pick : '0;

	assign item.hit     = scan_step & found;
	assign item.chan    = pick_id;
	assign item.payload = chan_payload[pick_id];

	always_ff @(posedge clk) begin
		if (reset) begin
			mask <= '0;
		end else if (scan_start) begin
			mask <= not_empty;
		end else if (scan_step) begin
			mask <= pending & ~pick;  // retire the channel just read
		end
	end

endmodule

// File: design/frame_builder.sv
// Frame sequencer.
// On an accepted frame_tick it pushes a header, sixteen data or filler
// words from the channel scan, and a trailer of fill counts, one word
// per cycle. A credit counter mirrors free space in the word FIFO.
`timescale 1ns/1ps
`include "readout_settings.svh"

module frame_builder (
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic                                               frame_tick,
	input  readout_pkg::chan_status_t [`READOUT_CHANNELS-1:0]  chan_status,
	input  logic [47:0]                                        dst_addr,
	input  logic [47:0]                                        src_addr,
	input  logic [7:0]                                         trigger_index,
	input  logic [7:0]                                         channel_linked,
	output logic                                               scan_start,
	output logic                                               scan_step,
	input  readout_pkg::scan_item_t                            item,
	output readout_pkg::frame_word_t                           word,
	output logic                                               push,
	input  logic                                               credit_return
);

	localparam int CREDIT_W = $clog2(`READOUT_FIFO_DEPTH + 1);
	localparam int ONES_W   = `READOUT_WORD_W - `READOUT_CHANNELS * `READOUT_FILL_W;

	logic                          active;        // frame in progress
	logic [4:0]                    slot;          // 1..16 data, 17 trailer
	logic [CREDIT_W-1:0]           credits;
	logic [7:0]                    packet_count;
	logic                          any_data;
	logic                          start;
	logic                          trailer_slot;
	logic [`READOUT_WORD_W-1:0]    header;
	logic [`READOUT_WORD_W-1:0]    slot_word;
	logic [`READOUT_WORD_W-1:0]    trailer;

	always_comb begin
		any_data = 1'b0;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			any_data = any_data | ~chan_status[i].empty;
		end
	end

	// need room for a whole frame, else the period is skipped
	assign start = frame_tick & ~active & any_data & (credits >= `READOUT_FRAME_WORDS);

	assign scan_start   = start;
	assign scan_step    = active & (slot <= 5'(`READOUT_DATA_SLOTS));
	assign trailer_slot = active & (slot == 5'(`READOUT_DATA_SLOTS + 1));

	// ============================================================
	// word formats
	// ============================================================
	assign header = {dst_addr, src_addr, trigger_index, packet_count, 8'hff};

	assign slot_word = item.hit ? {1'b1, item.chan, item.payload}
	                            : {{(`READOUT_WORD_W - 16){1'b0}}, 4'hf, 4'h0, channel_linked};

	always_comb begin
		trailer = {`READOUT_WORD_W{1'b1}};  // low 40 bits stay ones
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			trailer[ONES_W + i*`READOUT_FILL_W +: `READOUT_FILL_W] = chan_status[i].fill;
		end
	end

	// ============================================================
	// sequencing and credits
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			active       <= 1'b0;
			slot         <= '0;
			push         <= 1'b0;
			credits      <= CREDIT_W'(`READOUT_FIFO_DEPTH);
			packet_count <= '0;
		end else begin
			credits <= credits - CREDIT_W'(push) + CREDIT_W'(credit_return);
			push    <= start | active;
			if (start) begin
				active       <= 1'b1;
				slot         <= 5'd1;
				packet_count <= packet_count + 1'b1;
			end else if (active) begin
				slot <= slot + 1'b1;
				if (trailer_slot) begin
					active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			word.data <= header;
			word.last <= 1'b0;
		end else if (scan_step) begin
			word.data <= slot_word;
			word.last <= 1'b0;
		end else if (trailer_slot) begin
			word.data <= trailer;  // fill counts as of this cycle
			word.last <= 1'b1;
		end
	end

endmodule

// File: design/word_fifo.sv
// Synchronous word FIFO between frame assembly and the byte serializer.
// Read side is first-word-fall-through; each pop hands one credit back
// to the frame builder. Overflow is prevented upstream by the credits.
`timescale 1ns/1ps
`include "readout_settings.svh"

module word_fifo (
	input  logic                      clk,
	input  logic                      reset,
	input  readout_pkg::frame_word_t  word_in,
	input  logic                      push,
	output readout_pkg::frame_word_t  word_out,
	output logic                      not_empty,
	input  logic                      pop,
	output logic                      credit_return
);

	localparam int AW = $clog2(`READOUT_FIFO_DEPTH);

	readout_pkg::frame_word_t mem [`READOUT_FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;  // words held
	logic          rd;

	assign rd = pop & not_empty;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= word_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			wr_ptr        <= wr_ptr + AW'(push);
			rd_ptr        <= rd_ptr + AW'(rd);
			count         <= count + (AW+1)'(push) - (AW+1)'(rd);
			credit_return <= rd;  // slot freed, one cycle later
		end
	end

	assign not_empty = (count != '0);
	assign word_out  = mem[rd_ptr];

endmodule

// File: design/byte_serializer.sv
// Byte serializer for the transmit stream.
// Pops one word when idle, then shifts out 15 bytes MSB first on a
// valid/ready handshake. tx_last marks the final byte of a frame.
`timescale 1ns/1ps
`include "readout_settings.svh"

module byte_serializer (
	input  logic                      clk,
	input  logic                      reset,
	input  readout_pkg::frame_word_t  word,
	input  logic                      not_empty,
	output logic                      pop,
	output logic [7:0]                tx_data,
	output logic                      tx_valid,
	output logic                      tx_last,
	input  logic                      tx_ready
);

	logic                        busy;   // a word is being sent
	logic [3:0]                  cnt;    // byte index within the word
	logic [`READOUT_WORD_W-1:0]  shreg;
	logic                        wlast;  // loaded word ends a frame
	logic                        fire;
	logic                        final_byte;

	assign pop        = ~busy & not_empty;
	assign fire       = busy & tx_ready;
	assign final_byte = (cnt == 4'(`READOUT_WORD_BYTES - 1));

	// ============================================================
	// handshake control
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (pop) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (fire) begin
			if (final_byte) begin
				busy <= 1'b0;  // next word needs a pop cycle
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (pop) begin
			shreg <= word.data;
			wlast <= word.last;
		end else if (fire) begin
			shreg <= shreg << 8;
		end
	end

	assign tx_valid = busy;
	assign tx_data  = shreg[`READOUT_WORD_W-1 -: 8];
	assign tx_last  = busy & wlast & final_byte;  // byte 270 of the frame

endmodule

// File: design/readout_top.sv
// Top level of the readout controller.
// Chains timer, channel scan, frame builder, word FIFO and byte
// serializer; all run on clk with a synchronous reset.
`timescale 1ns/1ps
`include "readout_settings.svh"

module readout_top (
	input  logic                                                  clk,
	input  logic                                                  reset,
	input  logic [`READOUT_CHANNELS-1:0][`READOUT_PAYLOAD_W-1:0]  chan_payload,
	input  readout_pkg::chan_status_t [`READOUT_CHANNELS-1:0]     chan_status,
	input  logic [47:0]                                           dst_addr,
	input  logic [47:0]                                           src_addr,
	input  logic [7:0]                                            trigger_index,
	input  logic [7:0]                                            channel_linked,
	input  logic [`READOUT_PERIOD_W-1:0]                          counter_th,
	output logic [`READOUT_CHANNELS-1:0]                          chan_read,
	output logic [7:0]                                            tx_data,
	output logic                                                  tx_valid,
	output logic                                                  tx_last,
	input  logic                                                  tx_ready
);

	logic                     frame_tick;
	logic                     scan_start;
	logic                     scan_step;
	readout_pkg::scan_item_t  item;
	readout_pkg::frame_word_t fb_word;    // builder to FIFO
	logic                     push;
	logic                     credit_return;
	readout_pkg::frame_word_t fifo_word;  // FIFO to serializer
	logic                     not_empty;
	logic                     pop;

	readout_timer u_timer (
		.clk(clk), .reset(reset), .counter_th(counter_th), .frame_tick(frame_tick)
	);

	channel_scan u_scan (
		.clk(clk), .reset(reset), .scan_start(scan_start), .scan_step(scan_step),
		.chan_status(chan_status), .chan_payload(chan_payload),
		.chan_read(chan_read), .item(item)
	);

	frame_builder u_builder (
		.clk(clk), .reset(reset), .frame_tick(frame_tick), .chan_status(chan_status),
		.dst_addr(dst_addr), .src_addr(src_addr), .trigger_index(trigger_index),
		.channel_linked(channel_linked), .scan_start(scan_start), .scan_step(scan_step),
		.item(item), .word(fb_word), .push(push), .credit_return(credit_return)
	);

	word_fifo u_fifo (
		.clk(clk), .reset(reset), .word_in(fb_word), .push(push), .word_out(fifo_word),
		.not_empty(not_empty), .pop(pop), .credit_return(credit_return)
	);

	byte_serializer u_ser (
		.clk(clk), .reset(reset), .word(fifo_word), .not_empty(not_empty), .pop(pop),
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last), .tx_ready(tx_ready)
	);

endmodule

// File: tb/readout_asserts.sv
// Protocol assertions for the readout controller.
// Bound to readout_top; watches the scan strobes, the tx stream and
// the word FIFO level.
`timescale 1ns/1ps
`include "readout_settings.svh"

module readout_asserts (
	input logic                                               clk,
	input logic                                               reset,
	input readout_pkg::chan_status_t [`READOUT_CHANNELS-1:0]  chan_status,
	input logic [`READOUT_CHANNELS-1:0]                       chan_read,
	input logic [7:0]                                         tx_data,
	input logic                                               tx_valid,
	input logic                                               tx_last,
	input logic                                               tx_ready,
	input logic [5:0]                                         fifo_count
);

	localparam int FRAME_BYTES = `READOUT_FRAME_WORDS * `READOUT_WORD_BYTES;

	logic [`READOUT_CHANNELS-1:0] chan_empty;
	logic [8:0]                   beat;  // bytes accepted so far in this frame

	always_comb begin
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			chan_empty[i] = chan_status[i].empty;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			beat <= '0;
		end else if (tx_valid && tx_ready) begin
			beat <= (beat == 9'(FRAME_BYTES - 1)) ? '0 : beat + 1'b1;
		end
	end

	// at most one strobe and never on an empty channel
	a_read_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(chan_read) && ((chan_read & chan_empty) == '0))
		else $error("bad channel read strobe");

	// last flag only with valid and only on the final byte of a frame
	a_last_valid: assert property (@(posedge clk) disable iff (reset)
		(tx_last || tx_valid) |-> (tx_valid && (tx_last == (beat == 9'(FRAME_BYTES - 1)))))
		else $error("tx_last without tx_valid or away from the frame end");

	// held byte must not change under back-pressure
	a_tx_stable: assert property (@(posedge clk) disable iff (reset)
		(tx_valid && !tx_ready) |=> ($stable(tx_data) && $stable(tx_last) && tx_valid))
		else $error("tx byte changed while stalled");

	a_fifo_depth: assert property (@(posedge clk) disable iff (reset)
		fifo_count <= `READOUT_FIFO_DEPTH)
		else $error("word FIFO over depth");

endmodule

bind readout_top readout_asserts u_asserts (
	.clk(clk), .reset(reset), .chan_status(chan_status), .chan_read(chan_read),
	.tx_data(tx_data), .tx_valid(tx_valid), .tx_last(tx_last), .tx_ready(tx_ready),
	.fifo_count(u_fifo.count)
);

// File: tb/readout_tb.sv
// Testbench for the readout controller.
// Models the eight FWFT channel FIFOs with queues, predicts every frame from
// the queue contents at the first scan read, and checks the byte stream.
`timescale 1ns/1ps
`include "readout_settings.svh"

module readout_tb;

	localparam int TH        = 320;  // period is TH+1 cycles
	localparam int FILL_AT   = 200;  // channels refilled well clear of a frame
	localparam int N_PERIODS = 36;
	localparam int LIMIT     = N_PERIODS * (TH + 1) + 2000;
	localparam logic [47:0] DST    = 48'h0a1b2c3d4e5f;
	localparam logic [47:0] SRC    = 48'h665544332211;
	localparam logic [7:0]  TRIG   = 8'h5a;
	localparam logic [7:0]  LINKED = 8'hc3;

	logic clk;
	logic reset;
	logic [`READOUT_CHANNELS-1:0][`READOUT_PAYLOAD_W-1:0] chan_payload;
	readout_pkg::chan_status_t [`READOUT_CHANNELS-1:0]    chan_status;
	logic [`READOUT_CHANNELS-1:0] chan_read;
	logic [7:0] tx_data;
	logic       tx_valid;
	logic       tx_last;
	logic       tx_ready;

	logic [`READOUT_PAYLOAD_W-1:0] chq [`READOUT_CHANNELS][$];  // channel FIFO models
	logic [8:0] exp_q [$];  // {last, byte}
	logic [`READOUT_CHANNELS-1:0] rd_cap;
	int seed = 3;
	int mcnt = 0;         // mirror of the period counter
	int period = 0;
	int frame_win = 0;
	int frames = 0;
	int cycles = 0;
	int byte_idx = 0;
	int mismatches = 0;
	int other_errors = 0;

	readout_top u_readout_top (
		.clk(clk), .reset(reset), .chan_payload(chan_payload), .chan_status(chan_status),
		.dst_addr(DST), .src_addr(SRC), .trigger_index(TRIG), .channel_linked(LINKED),
		.counter_th(`READOUT_PERIOD_W'(TH)), .chan_read(chan_read), .tx_data(tx_data),
		.tx_valid(tx_valid), .tx_last(tx_last), .tx_ready(tx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ============================================================
	// reference model of one frame
	// ============================================================
	function automatic void build_frame(input logic [7:0] pkt);
		logic [`READOUT_WORD_W-1:0] w [`READOUT_FRAME_WORDS];
		int idx [`READOUT_CHANNELS];
		logic [`READOUT_CHANNELS-1:0] mask;
		logic [`READOUT_CHANNELS-1:0] pending;
		int pick;
		w[0] = {DST, SRC, TRIG, pkt, 8'hff};
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			idx[i]  = 0;
			mask[i] = (chq[i].size() != 0);
		end
		for (int s = 1; s <= `READOUT_DATA_SLOTS; s++) begin
			pending = mask;
			if (mask == '0) begin
				for (int i = 0; i < `READOUT_CHANNELS; i++) begin
					pending[i] = idx[i] < chq[i].size();
				end
			end
			pick = -1;
			for (int i = 0; i < `READOUT_CHANNELS; i++) begin
				if (pending[i]) begin
					pick = i;  // highest wins
				end
			end
			if (pick >= 0) begin
				w[s] = {1'b1, 3'(pick), chq[pick][idx[pick]]};
				idx[pick]++;
				pending[pick] = 1'b0;
			end else begin
				w[s] = {104'b0, 4'hf, 4'h0, LINKED};  // filler
			end
			mask = pending;
		end
		w[17] = '1;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			w[17][40 + i*10 +: 10] = 10'(chq[i].size() - idx[i]);  // fill left after the scan
		end
		for (int s = 0; s < `READOUT_FRAME_WORDS; s++) begin
			for (int b = 0; b < `READOUT_WORD_BYTES; b++) begin
				exp_q.push_back({(s == 17 && b == 14), w[s][119 - 8*b -: 8]});
			end
		end
	endfunction

	// ============================================================
	// compare process, frame detection and timeout
	// ============================================================
	always @(posedge clk) begin
		logic [8:0] e;
		cycles++;
		rd_cap = chan_read;
		if (!reset && chan_read != '0 && frame_win == 0) begin
			if (mcnt != 0) begin
				$display("frame started at %0t without a period tick", $time);
				other_errors++;
			end
			build_frame(8'(frames));  // header count before this frame
			frames++;
			frame_win = `READOUT_DATA_SLOTS;
		end else if (frame_win > 0) begin
			frame_win--;
		end
		if (tx_valid && tx_ready) begin
			if (exp_q.size() == 0) begin
				$display("byte sent at %0t with no frame expected", $time);
				other_errors++;
			end else begin
				e = exp_q.pop_front();
				if (tx_data !== e[7:0] || tx_last !== e[8]) begin
					$display("MISMATCH at %0t: byte %0d got %h last %b, expected %h last %b",
						$time, byte_idx, tx_data, tx_last, e[7:0], e[8]);
					mismatches++;
				end
				byte_idx++;
			end
		end
		if (reset || mcnt == TH) begin
			if (!reset) period++;
			mcnt = 0;
		end else begin
			mcnt++;
		end
		if (cycles >= LIMIT) begin
			$display("run timed out after %0d cycles with %0d bytes pending",
				cycles, exp_q.size());
			$display(">>> FAIL");
			$finish;
		end
	end

	// channel models and tx_ready driven on the falling edge
	always @(negedge clk) begin
		logic [31:0] r;
		logic [127:0] v;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			if (rd_cap[i]) begin
				if (chq[i].size() == 0) begin
					$display("channel %0d read at %0t while it held no data", i, $time);
					other_errors++;
				end else begin
					void'(chq[i].pop_front());
				end
			end
		end
		rd_cap = '0;
		if (!reset && mcnt == FILL_AT && (period < 8 || (period >= 11 && period < 23))) begin
			for (int i = 0; i < `READOUT_CHANNELS; i++) begin
				r = $random(seed);
				for (int k = 0; k < r[1:0]; k++) begin
					v = {$random(seed), $random(seed), $random(seed), $random(seed)};
					chq[i].push_back(v[`READOUT_PAYLOAD_W-1:0]);
				end
			end
		end
		r = $random(seed);
		if (period >= 11 && period < 19) tx_ready <= r[0];          // random back-pressure
		else if (period >= 19 && period < 23) tx_ready <= 1'b0;     // long stall
		else tx_ready <= 1'b1;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			chan_payload[i]      <= (chq[i].size() != 0) ? chq[i][0] : '0;
			chan_status[i].empty <= (chq[i].size() == 0);
			chan_status[i].fill  <= 10'(chq[i].size());
		end
	end

	initial begin
		reset        = 1'b1;
		tx_ready     = 1'b0;
		chan_payload = '0;
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			chan_status[i] = '{empty: 1'b1, fill: '0};
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		while (period < N_PERIODS || exp_q.size() != 0 || tx_valid) begin
			@(negedge clk);
		end
		@(negedge clk);
		for (int i = 0; i < `READOUT_CHANNELS; i++) begin
			if (chq[i].size() != 0) begin
				$display("channel %0d still holds %0d words at the end", i, chq[i].size());
				other_errors++;
			end
		end
		$display("frames %0d, bytes %0d, mismatches %0d, other errors %0d",
			frames, byte_idx, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+design
design/readout_pkg.sv
design/readout_timer.sv
design/channel_scan.sv
design/frame_builder.sv
design/word_fifo.sv
design/byte_serializer.sv
design/readout_top.sv
tb/readout_asserts.sv
tb/readout_tb.sv

// File: run.sh
#!/bin/bash
# builds and runs the readout testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module readout_tb \
	-f verilog.f -o readout_sim > build.log 2>&1 \
	&& ./obj_dir/readout_sim > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q ">>> PASS" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
